//--- hdl/x86_settings.svh
`ifndef X86_SETTINGS_SVH
`define X86_SETTINGS_SVH

// Datapath and register file geometry
`define X86_DATA_W   16
`define X86_REG_CNT  8

// Register start values after reset
`define X86_RESET_AX 16'h1254
`define X86_RESET_CX 16'h0440
`define X86_RESET_DX 16'h4010
`define X86_RESET_BX 16'h0201
`define X86_RESET_SP 16'h3024
`define X86_RESET_BP 16'h0342
`define X86_RESET_SI 16'h0430
`define X86_RESET_DI 16'h4003

`endif

//--- hdl/x86_regs_pkg.sv
`include "x86_settings.svh"

package x86_regs_pkg;

    // One register, seen whole or as its two byte halves
    typedef union packed {
        logic [`X86_DATA_W-1:0] word;
        struct packed {
            logic [`X86_DATA_W/2-1:0] hi; // AH..BH when index is 4..7
            logic [`X86_DATA_W/2-1:0] lo; // AL..BL
        } bytes;
    } reg_word_u;

    // Register numbering as in the ModRM reg/rm fields
    localparam logic [2:0] REG_AX = 3'd0;
    localparam logic [2:0] REG_CX = 3'd1;
    localparam logic [2:0] REG_DX = 3'd2;
    localparam logic [2:0] REG_BX = 3'd3;
    localparam logic [2:0] REG_SP = 3'd4;
    localparam logic [2:0] REG_BP = 3'd5;
    localparam logic [2:0] REG_SI = 3'd6;
    localparam logic [2:0] REG_DI = 3'd7;

endpackage

//--- hdl/x86_alu_pkg.sv
`include "x86_settings.svh"

package x86_alu_pkg;

    // Operation codes, taken straight from opcode bits 5:3
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_OR  = 3'd1;
    localparam logic [2:0] ALU_ADC = 3'd2;
    localparam logic [2:0] ALU_SBB = 3'd3;
    localparam logic [2:0] ALU_AND = 3'd4;
    localparam logic [2:0] ALU_SUB = 3'd5;
    localparam logic [2:0] ALU_XOR = 3'd6;
    localparam logic [2:0] ALU_CMP = 3'd7;

    // Bit positions in the 8086 flags word
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 2;
    localparam int FLAG_ZF = 6;
    localparam int FLAG_SF = 7;
    localparam int FLAG_OF = 11;

    // Flags implemented by this core, all others read as zero
    localparam logic [`X86_DATA_W-1:0] FLAG_MASK =
        (`X86_DATA_W'(1) << FLAG_CF) |
        (`X86_DATA_W'(1) << FLAG_PF) |
        (`X86_DATA_W'(1) << FLAG_ZF) |
        (`X86_DATA_W'(1) << FLAG_SF) |
        (`X86_DATA_W'(1) << FLAG_OF);

    // PF is set when the low byte holds an even number of ones
    function automatic logic parity8(input logic [7:0] value);
        logic odd;
        odd = ^value;
        return ~odd;
    endfunction

endpackage

//--- hdl/op_decoder.sv
module op_decoder
    import x86_alu_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       instr_valid,
    input  logic [7:0] opcode,
    input  logic [7:0] modrm,
    output logic [2:0] d_idx,
    output logic [2:0] s_idx,
    output logic       byte_mode,
    output logic [2:0] alu_op,
    output logic       write_en,
    output logic       exec_valid,
    output logic       illegal_req
);

    logic       is_illegal;
    logic       dir_bit;
    logic [2:0] op_field;
    logic [2:0] reg_field;
    logic [2:0] rm_field;

    assign dir_bit   = opcode[1];   // 1: reg is destination
    assign op_field  = opcode[5:3];
    assign reg_field = modrm[5:3];
    assign rm_field  = modrm[2:0];

    // Only 00h..3Fh with low bits 0..3 and register-direct ModRM
    assign is_illegal = (opcode[7:6] != 2'b00) ||
                        opcode[2] ||
                        (modrm[7:6] != 2'b11);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_valid  <= 1'b0;
            illegal_req <= 1'b0;
            write_en    <= 1'b0;
        end else begin
            exec_valid  <= instr_valid && !is_illegal;
            illegal_req <= instr_valid && is_illegal;
            write_en    <= instr_valid && !is_illegal && (op_field != ALU_CMP); // CMP keeps dest
        end
    end

    // Instruction fields, meaningful only while exec_valid is high
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            if (dir_bit) begin
                d_idx <= reg_field;
                s_idx <= rm_field;
            end else begin
                d_idx <= rm_field;
                s_idx <= reg_field;
            end
            byte_mode <= ~opcode[0];  // w bit clear means byte operands
            alu_op    <= op_field;
        end
    end

endmodule

//--- hdl/regfile.sv
`include "x86_settings.svh"

module regfile
    import x86_regs_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [2:0]             d_idx,
    input  logic [2:0]             s_idx,
    input  logic                   byte_mode,
    input  logic                   we,
    input  logic [`X86_DATA_W-1:0] wdata,
    output logic [`X86_DATA_W-1:0] d_data,
    output logic [`X86_DATA_W-1:0] s_data
);

    localparam int W = `X86_DATA_W;
    localparam int H = `X86_DATA_W / 2;

    reg_word_u regs [`X86_REG_CNT];

    logic [2:0] d_base; // Byte mode: owner of AL..BL / AH..BH

    assign d_base = {1'b0, d_idx[1:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs[REG_AX].word <= `X86_RESET_AX;
            regs[REG_CX].word <= `X86_RESET_CX;
            regs[REG_DX].word <= `X86_RESET_DX;
            regs[REG_BX].word <= `X86_RESET_BX;
            regs[REG_SP].word <= `X86_RESET_SP;
            regs[REG_BP].word <= `X86_RESET_BP;
            regs[REG_SI].word <= `X86_RESET_SI;
            regs[REG_DI].word <= `X86_RESET_DI;
        end else if (we) begin
            if (!byte_mode) begin
                regs[d_idx].word <= wdata;
            end else if (d_idx[2]) begin
                regs[d_base].bytes.hi <= wdata[H-1:0]; // AH, CH, DH, BH
            end else begin
                regs[d_base].bytes.lo <= wdata[H-1:0];
            end
        end
    end

    // Same aliasing on both read ports, bytes come back zero-extended
    function automatic logic [W-1:0] read_reg(input logic [2:0] idx, input logic bmode);
        logic [2:0] base;
        logic [H-1:0] sel_byte;
        base = {1'b0, idx[1:0]};
        sel_byte = idx[2] ? regs[base].bytes.hi : regs[base].bytes.lo;
        if (bmode) begin
            return {{H{1'b0}}, sel_byte};
        end
        return regs[idx].word;
    endfunction

    always_comb begin
        d_data = read_reg(d_idx, byte_mode); // Destination, ALU operand a
        s_data = read_reg(s_idx, byte_mode); // Source, ALU operand b
    end

endmodule

//--- hdl/alu.sv
`include "x86_settings.svh"

module alu
    import x86_alu_pkg::*;
    import x86_regs_pkg::*;
(
    input  logic [`X86_DATA_W-1:0] a,
    input  logic [`X86_DATA_W-1:0] b,
    input  logic                   byte_mode,
    input  logic [2:0]             alu_op,
    input  logic                   carry_in,
    output logic [`X86_DATA_W-1:0] alu_result,
    output logic [`X86_DATA_W-1:0] alu_flags
);

    localparam int W = `X86_DATA_W;
    localparam int H = `X86_DATA_W / 2;

    reg_word_u    a_u;
    reg_word_u    b_u;
    reg_word_u    res_u;
    logic [W:0]   raw;       // One extra bit for carry/borrow
    logic [W:0]   cin_w;
    logic [W:0]   a_w;
    logic [W:0]   b_w;
    logic         is_logic;
    logic         is_sub;
    logic         sign_a;
    logic         sign_b;
    logic         sign_r;
    logic         carry_out;
    logic         overflow;

    assign a_w   = {1'b0, a};
    assign b_w   = {1'b0, b};
    assign cin_w = {{W{1'b0}}, carry_in};

    always_comb begin
        raw      = '0;
        is_logic = 1'b0;
        is_sub   = 1'b0;
        unique case (alu_op)
            ALU_ADD: raw = a_w + b_w;
            ALU_ADC: raw = a_w + b_w + cin_w;
            ALU_SBB: begin
                raw    = a_w - b_w - cin_w;
                is_sub = 1'b1;
            end
            ALU_SUB, ALU_CMP: begin
                raw    = a_w - b_w; // CMP result only feeds the flags
                is_sub = 1'b1;
            end
            ALU_OR: begin
                raw      = a_w | b_w;
                is_logic = 1'b1;
            end
            ALU_AND: begin
                raw      = a_w & b_w;
                is_logic = 1'b1;
            end
            ALU_XOR: begin
                raw      = a_w ^ b_w;
                is_logic = 1'b1;
            end
        endcase
    end

    // Operands arrive zero-extended in byte mode
    always_comb begin
        a_u.word   = a;
        b_u.word   = b;
        res_u.word = raw[W-1:0];
        if (byte_mode) begin
            res_u.bytes.hi = '0;   // Truncate to 8 bits
        end
        sign_a    = byte_mode ? a_u.bytes.lo[H-1] : a_u.word[W-1];
        sign_b    = byte_mode ? b_u.bytes.lo[H-1] : b_u.word[W-1];
        sign_r    = byte_mode ? res_u.bytes.lo[H-1] : res_u.word[W-1];
        carry_out = byte_mode ? raw[H] : raw[W]; // Wrapped subtraction sets both
        if (is_sub) begin
            overflow = (sign_a != sign_b) && (sign_r != sign_a);
        end else begin
            overflow = (sign_a == sign_b) && (sign_r != sign_a);
        end
    end

    always_comb begin
        alu_result         = res_u.word;
        alu_flags          = '0;
        alu_flags[FLAG_CF] = carry_out && !is_logic;
        alu_flags[FLAG_PF] = parity8(res_u.bytes.lo);
        alu_flags[FLAG_ZF] = (res_u.word == '0);
        alu_flags[FLAG_SF] = sign_r;
        alu_flags[FLAG_OF] = overflow && !is_logic;
    end

endmodule

//--- hdl/retire_stage.sv
`include "x86_settings.svh"

module retire_stage
    import x86_alu_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   exec_valid,
    input  logic                   illegal_req,
    input  logic [`X86_DATA_W-1:0] alu_result,
    input  logic [`X86_DATA_W-1:0] alu_flags,
    output logic [`X86_DATA_W-1:0] result,
    output logic [`X86_DATA_W-1:0] flags,
    output logic                   done,
    output logic                   illegal
);

    // Architectural flags live here; the ALU reads CF back for ADC/SBB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            flags  <= '0;
        end else if (exec_valid) begin
            result <= alu_result;
            flags  <= alu_flags & FLAG_MASK; // Undefined bits stay zero
        end
    end

    // One pulse per accepted strobe, two edges after the sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            done    <= exec_valid;
            illegal <= illegal_req;
        end
    end

endmodule

//--- hdl/x86_exec_core.sv
`include "x86_settings.svh"

module x86_exec_core
    import x86_alu_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    input  logic [7:0]             opcode,
    input  logic [7:0]             modrm,
    output logic                   done,
    output logic                   illegal,
    output logic [`X86_DATA_W-1:0] result,
    output logic [`X86_DATA_W-1:0] flags
);

    logic [2:0]             d_idx;
    logic [2:0]             s_idx;
    logic                   byte_mode;
    logic [2:0]             alu_op;
    logic                   write_en;
    logic                   exec_valid;
    logic                   illegal_req;
    logic [`X86_DATA_W-1:0] d_data;
    logic [`X86_DATA_W-1:0] s_data;
    logic [`X86_DATA_W-1:0] alu_result;
    logic [`X86_DATA_W-1:0] alu_flags;

    op_decoder u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .modrm       (modrm),
        .d_idx       (d_idx),
        .s_idx       (s_idx),
        .byte_mode   (byte_mode),
        .alu_op      (alu_op),
        .write_en    (write_en),
        .exec_valid  (exec_valid),
        .illegal_req (illegal_req)
    );

    regfile u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .d_idx     (d_idx),
        .s_idx     (s_idx),
        .byte_mode (byte_mode),
        .we        (write_en),     // Already cleared for CMP
        .wdata     (alu_result),
        .d_data    (d_data),
        .s_data    (s_data)
    );

    alu u_alu (
        .a          (d_data),
        .b          (s_data),
        .byte_mode  (byte_mode),
        .alu_op     (alu_op),
        .carry_in   (flags[FLAG_CF]), // CF from the last retired op
        .alu_result (alu_result),
        .alu_flags  (alu_flags)
    );

    retire_stage u_retire (
        .clk         (clk),
        .arst_n      (arst_n),
        .exec_valid  (exec_valid),
        .illegal_req (illegal_req),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .result      (result),
        .flags       (flags),
        .done        (done),
        .illegal     (illegal)
    );

endmodule

//--- bench/tb_x86_exec_core.sv
`include "x86_settings.svh"

module tb_x86_exec_core
    import x86_alu_pkg::*;
    import x86_regs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_DIRECTED = 27;
    localparam int N_RANDOM   = 300;
    localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 4 + 50;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        instr_valid;
    logic [7:0]  opcode;
    logic [7:0]  modrm;
    logic        done;
    logic        illegal;
    logic [15:0] result;
    logic [15:0] flags;

    logic [15:0] model_regs [8];
    logic [15:0] model_flags;
    logic [15:0] model_result;

    string       name_q [$];     // Expected responses, in issue order
    logic [15:0] res_q [$];
    logic [15:0] flg_q [$];
    bit          ill_q [$];
    int          due_q [$];      // Cycle in which the pulse must show
    string       cur_name;
    logic [15:0] cur_res;
    logic [15:0] cur_flg;
    bit          cur_ill;
    int          cur_due;
    int          issued_cnt = 0;
    int          completed_cnt = 0;
    int          cycle_cnt = 0;

    x86_exec_core u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .modrm       (modrm),
        .done        (done),
        .illegal     (illegal),
        .result      (result),
        .flags       (flags)
    );

    always #10 clk = ~clk;

    // Byte indices 4..7 name the high halves of AX..BX
    function automatic logic [15:0] read_model(input logic [2:0] idx, input logic wide);
        if (wide) begin
            return model_regs[idx];
        end
        if (!idx[2]) begin
            return {8'h00, model_regs[{1'b0, idx[1:0]}][7:0]};
        end
        return {8'h00, model_regs[{1'b0, idx[1:0]}][15:8]};
    endfunction

    function automatic void write_model(input logic [2:0] idx, input logic wide,
                                        input logic [15:0] value);
        if (wide) begin
            model_regs[idx] = value;
        end else if (!idx[2]) begin
            model_regs[{1'b0, idx[1:0]}][7:0] = value[7:0];
        end else begin
            model_regs[{1'b0, idx[1:0]}][15:8] = value[7:0];
        end
    endfunction

    // Applies one instruction to the model, returns what the DUT should show
    function automatic void apply_model(input logic [7:0] op, input logic [7:0] mrm,
                                        output logic [15:0] exp_res,
                                        output logic [15:0] exp_flg,
                                        output bit exp_ill);
        logic [2:0]  dst;
        logic [2:0]  src;
        logic        wide;
        logic [31:0] mask;
        logic [31:0] top;
        logic [31:0] av;
        logic [31:0] bv;
        logic [31:0] cin;
        logic [31:0] full;
        logic [31:0] sub;
        logic [31:0] res;
        logic        cf;
        logic        ovf;
        int          ones;
        logic [15:0] f;
        exp_ill = (op[7:6] != 2'b00) || op[2] || (mrm[7:6] != 2'b11);
        if (exp_ill) begin
            exp_res = model_result; // Nothing retires
            exp_flg = model_flags;
            return;
        end
        wide = op[0];
        dst  = op[1] ? mrm[5:3] : mrm[2:0];
        src  = op[1] ? mrm[2:0] : mrm[5:3];
        mask = wide ? 32'h0000_ffff : 32'h0000_00ff;
        top  = wide ? 32'h0000_8000 : 32'h0000_0080;
        av   = {16'h0000, read_model(dst, wide)};
        bv   = {16'h0000, read_model(src, wide)};
        cin  = {31'd0, model_flags[FLAG_CF]};
        cf   = 1'b0;
        ovf  = 1'b0;
        case (op[5:3])
            ALU_ADD, ALU_ADC: begin
                full = av + bv + ((op[5:3] == ALU_ADC) ? cin : 32'd0);
                res  = full & mask;
                cf   = full > mask;
                ovf  = ((av & top) == (bv & top)) && ((res & top) != (av & top));
            end
            ALU_SUB, ALU_SBB, ALU_CMP: begin
                sub = bv + ((op[5:3] == ALU_SBB) ? cin : 32'd0);
                res = (av - sub) & mask;
                cf  = av < sub;    // Borrow
                ovf = ((av & top) != (bv & top)) && ((res & top) != (av & top));
            end
            ALU_OR:  res = av | bv;
            ALU_AND: res = av & bv;
            default: res = av ^ bv;
        endcase
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            if (res[i]) begin
                ones++;
            end
        end
        f = 16'h0000;
        f[FLAG_CF] = cf;
        f[FLAG_PF] = (ones % 2) == 0;
        f[FLAG_ZF] = res == 32'd0;
        f[FLAG_SF] = (res & top) != 32'd0;
        f[FLAG_OF] = ovf;
        if (op[5:3] != ALU_CMP) begin
            write_model(dst, wide, res[15:0]);
        end
        model_result = res[15:0];
        model_flags  = f;
        exp_res = model_result;
        exp_flg = model_flags;
    endfunction

    task automatic check_value(input string test_name, input string field,
                               input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, field, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue(input string name, input logic [7:0] op, input logic [7:0] mrm);
        logic [15:0] exp_res;
        logic [15:0] exp_flg;
        bit          exp_ill;
        @(posedge clk);
        instr_valid <= 1'b1;
        opcode      <= op;
        modrm       <= mrm;
        apply_model(op, mrm, exp_res, exp_flg, exp_ill);
        name_q.push_back(name);
        res_q.push_back(exp_res);
        flg_q.push_back(exp_flg);
        ill_q.push_back(exp_ill);
        due_q.push_back(cycle_cnt + 3); // Sampled next edge, pulse two edges on
        issued_cnt++;
    endtask

    task automatic idle();
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (done || illegal) begin
            if (name_q.size() == 0) begin
                $display("Unexpected completion pulse with no instruction outstanding");
                $display("Test FAILED");
                $fatal(1, "unexpected completion");
            end else begin
                cur_name = name_q.pop_front();
                cur_res  = res_q.pop_front();
                cur_flg  = flg_q.pop_front();
                cur_ill  = ill_q.pop_front();
                cur_due  = due_q.pop_front();
                check_value(cur_name, "latency", 16'(cur_due), 16'(cycle_cnt));
                check_value(cur_name, "illegal", {15'd0, cur_ill}, {15'd0, illegal});
                check_value(cur_name, "done", {15'd0, !cur_ill}, {15'd0, done});
                check_value(cur_name, "result", cur_res, result);
                check_value(cur_name, "flags", cur_flg, flags);
                completed_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, instructions still outstanding", cycle_cnt);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [7:0]  op;
        logic [7:0]  mrm;
        instr_valid <= 1'b0;
        opcode      <= 8'h00;
        modrm       <= 8'h00;
        arst_n      <= 1'b0;
        void'($urandom(32'hfc30));
        model_regs[REG_AX] = `X86_RESET_AX;
        model_regs[REG_CX] = `X86_RESET_CX;
        model_regs[REG_DX] = `X86_RESET_DX;
        model_regs[REG_BX] = `X86_RESET_BX;
        model_regs[REG_SP] = `X86_RESET_SP;
        model_regs[REG_BP] = `X86_RESET_BP;
        model_regs[REG_SI] = `X86_RESET_SI;
        model_regs[REG_DI] = `X86_RESET_DI;
        model_flags  = 16'h0000;
        model_result = 16'h0000;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Word ops from reset values, both directions
        issue("add_ax_cx_d1", 8'h03, 8'hc1);
        issue("add_cx_dx_d0", 8'h01, 8'hd1);
        issue("sub_bx_sp_d1", 8'h2b, 8'hdc);
        issue("sub_si_bp_d0", 8'h29, 8'hee);
        issue("xor_di_ax_d1", 8'h33, 8'hf8);
        issue("xor_dx_dx_d0", 8'h31, 8'hd2);
        // AH and BH alias the high bytes
        issue("add_ah_bl", 8'h02, 8'he3);
        issue("or_ax_ax", 8'h0b, 8'hc0);
        issue("sub_bh_ch_d0", 8'h28, 8'hef);
        issue("or_bx_bx", 8'h0b, 8'hdb);
        // Borrow then carry chain, back to back and after a gap
        issue("xor_cx_cx", 8'h33, 8'hc9);
        issue("sub_cx_di", 8'h2b, 8'hcf);
        issue("adc_dx_si", 8'h13, 8'hd6);
        issue("sbb_bp_bx", 8'h1b, 8'heb);
        issue("adc_ah_cl", 8'h12, 8'he1);
        idle();
        issue("sbb_si_dx_gap", 8'h1b, 8'hf2);
        // CMP leaves the destination alone
        issue("cmp_ax_bx", 8'h3b, 8'hc3);
        issue("or_ax_after_cmp", 8'h0b, 8'hc0);
        issue("cmp_ah_cl", 8'h3a, 8'he1);
        issue("or_ah_after_cmp", 8'h0a, 8'he4);
        // Refused encodings
        issue("illegal_mod00", 8'h03, 8'h01);
        issue("illegal_mod01", 8'h03, 8'h41);
        issue("illegal_mod10", 8'h2b, 8'h8b);
        issue("illegal_op40", 8'h40, 8'hc0);
        issue("illegal_op04", 8'h04, 8'hc0);
        issue("adc_after_illegal", 8'h13, 8'hc1);
        issue("or_ax_after_illegal", 8'h0b, 8'hc0);

        for (int i = 0; i < N_RANDOM; i++) begin
            ra = $urandom;
            rb = $urandom;
            if (ra[2:0] == 3'd0) begin
                op = ra[15:8];       // Mostly outside the ALU group
            end else begin
                op = {2'b00, ra[5:3], 1'b0, ra[7:6]};
            end
            if (rb[2:0] == 3'd0) begin
                mrm = rb[15:8];
            end else begin
                mrm = {2'b11, rb[13:8]};
            end
            issue($sformatf("rand_%0d", i), op, mrm);
        end
        idle();

        while (completed_cnt < issued_cnt) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // Room for a stray pulse to show up
        if (completed_cnt == issued_cnt && name_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Completion count %0d does not match %0d issued instructions",
                     completed_cnt, issued_cnt);
            $display("Test FAILED");
            $fatal(1, "count mismatch");
        end
    end

endmodule

//--- x86_exec_core.f
+incdir+hdl
hdl/x86_regs_pkg.sv
hdl/x86_alu_pkg.sv
hdl/op_decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/retire_stage.sv
hdl/x86_exec_core.sv
bench/tb_x86_exec_core.sv

//--- Makefile
SIM      := verilator
TOP      := tb_x86_exec_core
FILELIST := x86_exec_core.f
FLAGS    := --binary --timing --timescale 1ns/100ps -j 0
OBJ_DIR  := obj_dir
PASS_MSG := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
